//--- src/riscv_mem_sys_macros.svh
`ifndef RISCV_MEM_SYS_MACROS_SVH
`define RISCV_MEM_SYS_MACROS_SVH

// data and address width of RV32
`define XLEN 32
`define BE_W 4

// host control word bits
`define CTRL_START_BIT 0
`define CTRL_CLEAR_BIT 2

// address map, core side
`define PERIPH_BASE 32'h8000_0000
`define END_ADDR    32'h0000_0ffc

// clocks between end store and stop
`define DRAIN_CYCLES 30

`endif

//--- src/riscv_mem_sys_pkg.sv
`include "riscv_mem_sys_macros.svh"

package riscv_mem_sys_pkg;

   typedef logic [`XLEN-1:0] word_t;
   typedef logic [`XLEN-1:0] addr_t;
   typedef logic [`BE_W-1:0] byte_en_t;
   typedef logic [`XLEN-1:0] cycle_cnt_t;

   typedef enum logic [1:0] {
      RUN_IDLE,
      RUN_ACTIVE,
      RUN_DRAIN,
      RUN_STOPPED
   } run_state_e;

   // core side request, held until gnt
   typedef struct packed {
      logic     req;
      logic     we;
      byte_en_t be;
      addr_t    addr;
      word_t    wdata;
   } mem_req_t;

   typedef struct packed {
      logic  gnt;
      logic  rvalid;
      word_t rdata;
   } mem_rsp_t;

   // block-RAM port B, driven towards the RAM
   typedef struct packed {
      logic     en;
      logic     rst;
      byte_en_t we;
      addr_t    addr;
      word_t    din;
   } bram_out_t;

   typedef struct packed {
      logic  rst_busy;
      word_t dout;
   } bram_in_t;

endpackage

//--- src/gpio_edge_pulse.sv
`include "riscv_mem_sys_macros.svh"

module gpio_edge_pulse import riscv_mem_sys_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  word_t ctrl_word_i,
   output logic  start_pulse_o,
   output logic  clear_pulse_o
);

   logic start_q;
   logic clear_q;

   // previous level of each command bit, pulse on 0 -> 1
   always_ff @(posedge clk) begin
      if (reset) begin
         start_q       <= 1'b0;
         clear_q       <= 1'b0;
         start_pulse_o <= 1'b0;
         clear_pulse_o <= 1'b0;
      end else begin
         start_q       <= ctrl_word_i[`CTRL_START_BIT];
         clear_q       <= ctrl_word_i[`CTRL_CLEAR_BIT];
         start_pulse_o <= ctrl_word_i[`CTRL_START_BIT] & ~start_q;
         clear_pulse_o <= ctrl_word_i[`CTRL_CLEAR_BIT] & ~clear_q;
      end
   end

endmodule

//--- src/run_controller.sv
`include "riscv_mem_sys_macros.svh"

module run_controller import riscv_mem_sys_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       start_pulse_i,
   input  logic       clear_pulse_i,
   input  logic       end_store_i,
   input  word_t      end_data_i,
   input  word_t      success_code_i,
   output logic       run_enable_o,
   output logic       running_o,
   output logic       stop_o,
   output cycle_cnt_t cycle_count_o
);

   localparam int DRAIN_W = $clog2(`DRAIN_CYCLES + 1);

   run_state_e         state_q;
   cycle_cnt_t         cycle_cnt_q;
   logic [DRAIN_W-1:0] drain_cnt_q;
   logic               stop_q;
   logic               end_match;
   logic               in_run;

   // only the success code ends a run, other values are ordinary stores
   assign end_match = end_store_i && (end_data_i == success_code_i);

   // a run stays in progress through the drain window
   assign in_run = (state_q == RUN_ACTIVE) || (state_q == RUN_DRAIN);

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q     <= RUN_IDLE;
         cycle_cnt_q <= '0;
         drain_cnt_q <= '0;
         stop_q      <= 1'b0;
      end else if (clear_pulse_i) begin
         state_q     <= RUN_IDLE;
         cycle_cnt_q <= '0;
         drain_cnt_q <= '0;
         stop_q      <= 1'b0;
      end else begin
         case (state_q)
            RUN_IDLE: begin
               if (start_pulse_i) begin
                  state_q     <= RUN_ACTIVE;
                  cycle_cnt_q <= '0;
               end
            end
            RUN_ACTIVE: begin
               cycle_cnt_q <= cycle_cnt_q + 1'b1;
               if (end_match) begin
                  state_q     <= RUN_DRAIN;
                  drain_cnt_q <= '0;
               end
            end
            RUN_DRAIN: begin
               cycle_cnt_q <= cycle_cnt_q + 1'b1;
               // let in-flight accesses settle before stopping
               if (drain_cnt_q == DRAIN_W'(`DRAIN_CYCLES - 1)) begin
                  state_q <= RUN_STOPPED;
                  stop_q  <= 1'b1;
               end else begin
                  drain_cnt_q <= drain_cnt_q + 1'b1;
               end
            end
            default: begin
               // stopped, wait for clear
               state_q <= RUN_STOPPED;
            end
         endcase
      end
   end

   assign run_enable_o  = in_run;
   assign running_o     = in_run;
   assign stop_o        = stop_q;
   assign cycle_count_o = cycle_cnt_q;

endmodule

//--- src/data_port_router.sv
`include "riscv_mem_sys_macros.svh"

module data_port_router import riscv_mem_sys_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     run_enable_i,
   input  addr_t    mem_offset_i,
   input  mem_req_t core_req_i,
   input  mem_rsp_t data_rsp_i,
   input  mem_rsp_t periph_rsp_i,
   output mem_rsp_t core_rsp_o,
   output mem_req_t data_req_o,
   output mem_req_t periph_req_o,
   output logic     end_store_o,
   output word_t    end_data_o
);

   logic  periph_sel;
   logic  core_req;
   logic  core_gnt;
   logic  accept;
   logic  end_hit;
   logic  rd_periph_q;
   logic  end_store_q;
   word_t end_data_q;

   // everything from the peripheral base upwards goes to the peripheral RAM
   assign periph_sel = (core_req_i.addr >= `PERIPH_BASE);

   // no access reaches a RAM outside a run
   assign core_req = core_req_i.req & run_enable_i;

   always_comb begin
      data_req_o       = core_req_i;
      data_req_o.req   = core_req & ~periph_sel;
      data_req_o.addr  = core_req_i.addr - mem_offset_i;

      periph_req_o     = core_req_i;
      periph_req_o.req = core_req & periph_sel;
   end

   assign core_gnt = periph_sel ? periph_rsp_i.gnt : data_rsp_i.gnt;
   assign accept   = core_req & core_gnt;
   assign end_hit  = accept & core_req_i.we & (core_req_i.addr == `END_ADDR);

   // remember which RAM took the read
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_periph_q <= 1'b0;
      end else if (accept && !core_req_i.we) begin
         rd_periph_q <= periph_sel;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         end_store_q <= 1'b0;
      end else begin
         end_store_q <= end_hit;
      end
   end

   // stored word of the end store
   always_ff @(posedge clk) begin
      if (end_hit) begin
         end_data_q <= core_req_i.wdata;
      end
   end

   always_comb begin
      core_rsp_o.gnt = core_gnt;
      if (rd_periph_q) begin
         core_rsp_o.rvalid = periph_rsp_i.rvalid;
         core_rsp_o.rdata  = periph_rsp_i.rdata;
      end else begin
         core_rsp_o.rvalid = data_rsp_i.rvalid;
         core_rsp_o.rdata  = data_rsp_i.rdata;
      end
   end

   assign end_store_o = end_store_q;
   assign end_data_o  = end_data_q;

endmodule

//--- src/bram_port_adapter.sv
module bram_port_adapter import riscv_mem_sys_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  mem_req_t  req_i,
   input  bram_in_t  ram_i,
   output mem_rsp_t  rsp_o,
   output bram_out_t ram_o
);

   logic accept;
   logic rvalid_q;

   // the RAM takes a request whenever it is out of its own reset
   assign accept = req_i.req & ~ram_i.rst_busy;

   always_comb begin
      ram_o.en   = accept;
      ram_o.rst  = reset;
      ram_o.addr = req_i.addr;
      ram_o.din  = req_i.wdata;
      if (accept && req_i.we) begin
         ram_o.we = req_i.be;
      end else begin
         ram_o.we = '0;
      end
   end

   // one cycle of read latency in the block RAM
   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept & ~req_i.we;
      end
   end

   always_comb begin
      rsp_o.gnt    = accept;
      rsp_o.rvalid = rvalid_q;
      rsp_o.rdata  = ram_i.dout;
   end

endmodule

//--- src/riscv_mem_sys.sv
module riscv_mem_sys import riscv_mem_sys_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      ctrl_word_i,
   input  addr_t      mem_offset_i,
   input  word_t      success_code_i,
   input  mem_req_t   core_req_i,
   input  bram_in_t   data_bram_i,
   input  bram_in_t   periph_bram_i,
   output mem_rsp_t   core_rsp_o,
   output bram_out_t  data_bram_o,
   output bram_out_t  periph_bram_o,
   output logic       stop_o,
   output logic       running_o,
   output cycle_cnt_t cycle_count_o
);

   logic     start_pulse;
   logic     clear_pulse;
   logic     run_enable;
   logic     end_store;
   word_t    end_data;
   mem_req_t data_req;
   mem_req_t periph_req;
   mem_rsp_t data_rsp;
   mem_rsp_t periph_rsp;

   gpio_edge_pulse u_gpio_edge_pulse (
      .clk           (clk),
      .reset         (reset),
      .ctrl_word_i   (ctrl_word_i),
      .start_pulse_o (start_pulse),
      .clear_pulse_o (clear_pulse)
   );

   run_controller u_run_controller (
      .clk            (clk),
      .reset          (reset),
      .start_pulse_i  (start_pulse),
      .clear_pulse_i  (clear_pulse),
      .end_store_i    (end_store),
      .end_data_i     (end_data),
      .success_code_i (success_code_i),
      .run_enable_o   (run_enable),
      .running_o      (running_o),
      .stop_o         (stop_o),
      .cycle_count_o  (cycle_count_o)
   );

   data_port_router u_data_port_router (
      .clk          (clk),
      .reset        (reset),
      .run_enable_i (run_enable),
      .mem_offset_i (mem_offset_i),
      .core_req_i   (core_req_i),
      .data_rsp_i   (data_rsp),
      .periph_rsp_i (periph_rsp),
      .core_rsp_o   (core_rsp_o),
      .data_req_o   (data_req),
      .periph_req_o (periph_req),
      .end_store_o  (end_store),
      .end_data_o   (end_data)
   );

   // data memory
   bram_port_adapter u_data_bram (
      .clk   (clk),
      .reset (reset),
      .req_i (data_req),
      .ram_i (data_bram_i),
      .rsp_o (data_rsp),
      .ram_o (data_bram_o)
   );

   // peripheral memory
   bram_port_adapter u_periph_bram (
      .clk   (clk),
      .reset (reset),
      .req_i (periph_req),
      .ram_i (periph_bram_i),
      .rsp_o (periph_rsp),
      .ram_o (periph_bram_o)
   );

endmodule

//--- test/riscv_mem_sys_assertions.sv
module riscv_mem_sys_assertions import riscv_mem_sys_pkg::*; (
   input logic     clk,
   input logic     reset,
   input mem_req_t core_req_i,
   input mem_rsp_t core_rsp_i,
   input logic     data_en_i,
   input logic     periph_en_i,
   input logic     running_i,
   input logic     stop_i,
   input logic     clear_pulse_i
);

   // read data only follows a read taken on the previous edge
   rvalid_after_read: assert property (@(posedge clk) disable iff (reset)
      core_rsp_i.rvalid |-> $past(core_req_i.req && core_rsp_i.gnt && !core_req_i.we)
   ) else $error("rvalid without an accepted read on the previous edge");

   one_ram_enabled: assert property (@(posedge clk) disable iff (reset)
      !(data_en_i && periph_en_i)
   ) else $error("both RAM ports enabled in the same cycle");

   no_grant_when_idle: assert property (@(posedge clk) disable iff (reset)
      (!running_i && !stop_i) |-> !core_rsp_i.gnt
   ) else $error("core request granted while the run is idle");

   // only the clear command takes the stop flag down
   stop_held: assert property (@(posedge clk) disable iff (reset)
      (stop_i && !clear_pulse_i) |=> stop_i
   ) else $error("stop flag dropped without a clear");

endmodule

bind riscv_mem_sys riscv_mem_sys_assertions u_assertions (
   .clk           (clk),
   .reset         (reset),
   .core_req_i    (core_req_i),
   .core_rsp_i    (core_rsp_o),
   .data_en_i     (data_bram_o.en),
   .periph_en_i   (periph_bram_o.en),
   .running_i     (running_o),
   .stop_i        (stop_o),
   .clear_pulse_i (clear_pulse)
);

//--- test/tb_riscv_mem_sys.sv
`include "riscv_mem_sys_macros.svh"

module tb_riscv_mem_sys import riscv_mem_sys_pkg::*; ();

   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYCLES = 8;
   localparam int GNT_TIMEOUT = 20;
   localparam int ROUTE_OPS = 16;
   // the routing test dominates with two accesses per operation
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * ROUTE_OPS * (GNT_TIMEOUT + 3)
                                    + 6 * (2 * `DRAIN_CYCLES + 4 * GNT_TIMEOUT);
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   localparam word_t START_WORD = word_t'(1) << `CTRL_START_BIT;
   localparam word_t CLEAR_WORD = word_t'(1) << `CTRL_CLEAR_BIT;

   logic        clk;
   logic        reset;
   word_t       ctrl_word;
   addr_t       mem_offset;
   word_t       success_code;
   mem_req_t    core_req;
   mem_rsp_t    core_rsp;
   bram_in_t    data_bram_in;
   bram_in_t    periph_bram_in;
   bram_out_t   data_bram_out;
   bram_out_t   periph_bram_out;
   logic        data_busy;
   logic        periph_busy;
   word_t       data_dout = '0;
   word_t       periph_dout = '0;
   logic        stop;
   logic        running;
   cycle_cnt_t  cycle_count;
   word_t       data_mem [addr_t];
   word_t       periph_mem [addr_t];
   logic [31:0] lfsr_state = 32'h1cf5_294d;
   int          error_count = 0;
   int          check_count = 0;
   int          test_count = 0;

   assign data_bram_in   = {data_busy, data_dout};
   assign periph_bram_in = {periph_busy, periph_dout};

   riscv_mem_sys i_riscv_mem_sys (
      .clk            (clk),
      .reset          (reset),
      .ctrl_word_i    (ctrl_word),
      .mem_offset_i   (mem_offset),
      .success_code_i (success_code),
      .core_req_i     (core_req),
      .data_bram_i    (data_bram_in),
      .periph_bram_i  (periph_bram_in),
      .core_rsp_o     (core_rsp),
      .data_bram_o    (data_bram_out),
      .periph_bram_o  (periph_bram_out),
      .stop_o         (stop),
      .running_o      (running),
      .cycle_count_o  (cycle_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic word_t merge_bytes(input word_t old_word, input word_t din,
                                         input byte_en_t we);
      word_t merged;
      merged = old_word;
      for (int b = 0; b < `BE_W; b++) begin
         if (we[b]) merged[8*b +: 8] = din[8*b +: 8];
      end
      return merged;
   endfunction

   // unwritten locations read back a pattern of their address
   function automatic word_t fill_word(input addr_t addr);
      return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
   endfunction

   // block RAM models with one cycle of read latency
   always @(posedge clk) begin
      word_t old_word;
      if (data_bram_out.en) begin
         old_word = data_mem.exists(data_bram_out.addr) ? data_mem[data_bram_out.addr]
                                                        : fill_word(data_bram_out.addr);
         if (data_bram_out.we != '0) begin
            data_mem[data_bram_out.addr] = merge_bytes(old_word, data_bram_out.din,
                                                       data_bram_out.we);
         end else begin
            data_dout <= old_word;
         end
      end
   end

   always @(posedge clk) begin
      word_t old_word;
      if (periph_bram_out.en) begin
         old_word = periph_mem.exists(periph_bram_out.addr) ? periph_mem[periph_bram_out.addr]
                                                            : fill_word(periph_bram_out.addr);
         if (periph_bram_out.we != '0) begin
            periph_mem[periph_bram_out.addr] = merge_bytes(old_word, periph_bram_out.din,
                                                           periph_bram_out.we);
         end else begin
            periph_dout <= old_word;
         end
      end
   end

   // galois LFSR stepped once per bit taken
   function automatic logic [31:0] random_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[30:0], lfsr_state[0]};
         if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
         else lfsr_state = lfsr_state >> 1;
      end
      return value;
   endfunction

   task automatic compare(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic note_failure(input string what);
      error_count++;
      $display("error at %0t: %s", $time, what);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) $display("test %s passed", name);
      else $display("test %s failed with %0d errors", name, error_count - errors_before);
   endtask

   task automatic wait_status(input logic want_running, input logic want_stop,
                              input int limit, output int cycles);
      cycles = 0;
      @(negedge clk);
      while ({running, stop} !== {want_running, want_stop} && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if ({running, stop} !== {want_running, want_stop}) begin
         note_failure($sformatf("running_o/stop_o stayed %b%b instead of %b%b for %0d cycles",
                                running, stop, want_running, want_stop, limit));
      end
   endtask

   task automatic drive_request(input logic we, input addr_t addr, input word_t wdata);
      @(posedge clk);
      core_req <= '{req: 1'b1, we: we, be: '1, addr: addr, wdata: wdata};
   endtask

   task automatic drop_request();
      @(posedge clk);
      core_req <= '0;
   endtask

   // a pending request sees no grant and no RAM enable
   task automatic expect_stall(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         compare("core gnt", 32'(core_rsp.gnt), 0);
         compare("data RAM en", 32'(data_bram_out.en), 0);
         compare("periph RAM en", 32'(periph_bram_out.en), 0);
      end
   endtask

   task automatic complete_request(output word_t rdata);
      int        waited;
      logic      periph;
      logic      we;
      bram_out_t port;
      waited = 0;
      @(negedge clk);
      periph = (core_req.addr >= `PERIPH_BASE);
      we = core_req.we;
      while (!core_rsp.gnt && waited < GNT_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!core_rsp.gnt) begin
         note_failure($sformatf("request to %h was never granted", core_req.addr));
      end else begin
         port = periph ? periph_bram_out : data_bram_out;
         compare("other RAM en", 32'(periph ? data_bram_out.en : periph_bram_out.en), 0);
         compare("RAM en", 32'(port.en), 1);
         compare("RAM addr", port.addr, periph ? core_req.addr : core_req.addr - mem_offset);
         compare("RAM we", 32'(port.we), we ? 32'(core_req.be) : 32'h0);
         if (we) compare("RAM din", port.din, core_req.wdata);
      end
      @(posedge clk);
      core_req <= '0;
      @(negedge clk);
      compare("core rvalid", 32'(core_rsp.rvalid), 32'(!we));
      rdata = core_rsp.rdata;
   endtask

   task automatic access(input logic we, input addr_t addr, input word_t wdata,
                         output word_t rdata);
      drive_request(we, addr, wdata);
      complete_request(rdata);
   endtask

   task automatic check_counting(input int cycles);
      cycle_cnt_t first;
      @(negedge clk);
      first = cycle_count;
      for (int i = 1; i <= cycles; i++) begin
         @(negedge clk);
         compare("cycle_count_o", cycle_count, first + cycle_cnt_t'(i));
      end
   endtask

   task automatic test_reset_state();
      int errors_before;
      errors_before = error_count;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      compare("data RAM rst", 32'(data_bram_out.rst), 1);
      compare("periph RAM rst", 32'(periph_bram_out.rst), 1);
      @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare("stop_o", 32'(stop), 0);
      compare("running_o", 32'(running), 0);
      compare("core rvalid", 32'(core_rsp.rvalid), 0);
      compare("data RAM we", 32'(data_bram_out.we), 0);
      compare("periph RAM we", 32'(periph_bram_out.we), 0);
      compare("data RAM rst", 32'(data_bram_out.rst), 0);
      compare("cycle_count_o", cycle_count, 0);
      // a request must wait for the start
      drive_request(1'b0, mem_offset, '0);
      expect_stall(4);
      drop_request();
      finish_test("reset_state", errors_before);
   endtask

   task automatic test_start_counting();
      int errors_before;
      int edges;
      errors_before = error_count;
      @(posedge clk);
      ctrl_word <= START_WORD;
      wait_status(1'b1, 1'b0, GNT_TIMEOUT, edges);
      compare("start to running edges", edges, 2);
      // start bit stays high and the count must never restart
      check_counting(12);
      finish_test("start_counting", errors_before);
   endtask

   task automatic test_routing();
      int    errors_before;
      logic  periph;
      addr_t addr;
      word_t wdata;
      word_t rdata;
      errors_before = error_count;
      for (int i = 0; i < ROUTE_OPS; i++) begin
         periph = (random_bits(1) != 0);
         addr = random_bits(29) << 2;
         addr[31] = periph;
         if (addr == `END_ADDR) addr = addr ^ 32'h10;
         wdata = random_bits(32);
         access(1'b1, addr, wdata, rdata);
         access(1'b0, addr, '0, rdata);
         compare("core rdata", rdata, wdata);
      end
      finish_test("routing", errors_before);
   endtask

   task automatic test_back_pressure();
      int    errors_before;
      addr_t addr;
      word_t wdata;
      word_t rdata;
      errors_before = error_count;
      addr = random_bits(29) << 2;
      wdata = random_bits(32);
      @(posedge clk);
      data_busy <= 1'b1;
      drive_request(1'b1, addr, wdata);
      expect_stall(5);
      @(posedge clk);
      data_busy <= 1'b0;
      complete_request(rdata);
      access(1'b0, addr, '0, rdata);
      compare("core rdata", rdata, wdata);
      finish_test("back_pressure", errors_before);
   endtask

   task automatic test_end_detection();
      int    errors_before;
      int    cycles;
      word_t rdata;
      errors_before = error_count;
      access(1'b1, `END_ADDR, success_code ^ 32'h1, rdata);
      repeat (`DRAIN_CYCLES + 4) begin
         @(negedge clk);
         compare("stop_o", 32'(stop), 0);
      end
      access(1'b1, `END_ADDR, success_code, rdata);
      wait_status(1'b0, 1'b1, `DRAIN_CYCLES + GNT_TIMEOUT, cycles);
      // counting starts one edge after the accepting edge
      if (stop && (cycles + 1 < `DRAIN_CYCLES || cycles + 1 > `DRAIN_CYCLES + 2)) begin
         note_failure($sformatf("stop_o rose %0d cycles after the end store", cycles + 1));
      end
      drive_request(1'b1, mem_offset, '0);
      expect_stall(4);
      drop_request();
      finish_test("end_detection", errors_before);
   endtask

   task automatic test_clear();
      int    errors_before;
      int    cycles;
      addr_t addr;
      word_t wdata;
      word_t rdata;
      errors_before = error_count;
      @(posedge clk);
      ctrl_word <= START_WORD | CLEAR_WORD;
      wait_status(1'b0, 1'b0, GNT_TIMEOUT, cycles);
      compare("cycle_count_o", cycle_count, 0);
      @(posedge clk);
      ctrl_word <= '0;
      drive_request(1'b1, `PERIPH_BASE, 32'h1);
      expect_stall(4);
      drop_request();
      @(posedge clk);
      ctrl_word <= START_WORD;
      wait_status(1'b1, 1'b0, GNT_TIMEOUT, cycles);
      check_counting(8);
      addr = `PERIPH_BASE | (random_bits(29) << 2);
      wdata = random_bits(32);
      access(1'b1, addr, wdata, rdata);
      access(1'b0, addr, '0, rdata);
      compare("core rdata", rdata, wdata);
      finish_test("clear", errors_before);
   endtask

   initial begin
      reset = 1'b1;
      ctrl_word = '0;
      mem_offset = 32'h0000_4000;
      success_code = 32'hc0de_600d;
      core_req = '0;
      data_busy = 1'b0;
      periph_busy = 1'b0;
      test_reset_state();
      test_start_counting();
      test_routing();
      test_back_pressure();
      test_end_detection();
      test_clear();
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("error: the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

endmodule

//--- riscv_mem_sys.f
+incdir+src
src/riscv_mem_sys_pkg.sv
src/gpio_edge_pulse.sv
src/run_controller.sv
src/data_port_router.sv
src/bram_port_adapter.sv
src/riscv_mem_sys.sv
test/riscv_mem_sys_assertions.sv
test/tb_riscv_mem_sys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, result decided from the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
   --top-module tb_riscv_mem_sys \
   -f riscv_mem_sys.f \
   -o tb_riscv_mem_sys

./obj_dir/tb_riscv_mem_sys | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi
